// File: rtl/aluPkg.sv
package aluPkg;

  // Data path
  localparam int DATA_W = 16;  // Word width of operands and results
  localparam int OP_W   = 4;   // ALU opcode field width

  //////////////////////////////
  // ALU opcodes
  //////////////////////////////
  localparam logic [OP_W-1:0] OP_ADD    = 4'd0;  // Saturating add
  localparam logic [OP_W-1:0] OP_SUB    = 4'd1;  // Saturating subtract
  localparam logic [OP_W-1:0] OP_XOR    = 4'd2;  // Bitwise xor
  localparam logic [OP_W-1:0] OP_RED    = 4'd3;  // Byte reduction add
  localparam logic [OP_W-1:0] OP_SLL    = 4'd4;  // Logical shift left
  localparam logic [OP_W-1:0] OP_SRA    = 4'd5;  // Arithmetic shift right
  localparam logic [OP_W-1:0] OP_ROR    = 4'd6;  // Rotate right
  localparam logic [OP_W-1:0] OP_PADDSB = 4'd7;  // Nibble-parallel saturating add
  localparam logic [OP_W-1:0] OP_LLB    = 4'd8;  // Load low byte
  localparam logic [OP_W-1:0] OP_LHB    = 4'd9;  // Load high byte
  // Codes 10 to 15 give a zero result

  //////////////////////////////
  // Flag vector layout
  //////////////////////////////
  localparam int FLAG_W = 3;  // Z, V and N
  localparam int FLAG_Z = 2;  // Zero
  localparam int FLAG_V = 1;  // Overflow, ADD and SUB only
  localparam int FLAG_N = 0;  // Negative

endpackage

// File: rtl/pipePkg.sv
package pipePkg;

  // Register file addressing
  localparam int REG_W = 4;  // 16 architectural registers, r0 reads as zero

  //////////////////////////////
  // Forward-select codes
  //////////////////////////////
  localparam int FWD_W = 2;                      // Select field width
  localparam logic [FWD_W-1:0] FWD_NONE  = 2'd0;  // Operand from ID/EX read data
  localparam logic [FWD_W-1:0] FWD_MEMWB = 2'd1;  // Operand from MEM/WB result
  localparam logic [FWD_W-1:0] FWD_EXMEM = 2'd2;  // Operand from EX/MEM result

endpackage

// File: rtl/fwdIf.sv
// In-flight results fed back from the pipeline registers
interface fwdIf import aluPkg::*, pipePkg::*; ();

  // EX/MEM stage
  logic [REG_W-1:0]  exMemRd;      // Destination register
  logic              exMemWrite;   // Writes a register
  logic [DATA_W-1:0] exMemResult;  // ALU result one cycle old

  // MEM/WB stage
  logic [REG_W-1:0]  memWbRd;      // Destination register
  logic              memWbWrite;   // Writes a register
  logic [DATA_W-1:0] memWbResult;  // ALU result two cycles old

  // Driven by the result pipeline
  modport source (
    output exMemRd, exMemWrite, exMemResult,
    output memWbRd, memWbWrite, memWbResult
  );

  // Read by forwarding logic and operand muxes
  modport sink (
    input exMemRd, exMemWrite, exMemResult,
    input memWbRd, memWbWrite, memWbResult
  );

endinterface

// File: rtl/Alu.sv
module Alu import aluPkg::*; (
  input  logic [DATA_W-1:0] in1,     // Operand A
  input  logic [DATA_W-1:0] in2,     // Operand B or immediate
  input  logic [OP_W-1:0]   opcode,  // Operation select
  output logic [DATA_W-1:0] result,  // Operation result
  output logic              zSet,    // Result is zero
  output logic              nSet,    // Result sign bit
  output logic              vSet     // ADD or SUB saturated
);

  logic [DATA_W-1:0]   sum;      // Raw add
  logic [DATA_W-1:0]   diff;     // Raw subtract
  logic                sumOvf;   // Add overflowed
  logic                diffOvf;  // Subtract overflowed
  logic [DATA_W-1:0]   satWord;  // Clamp value, sign follows in1
  logic [8:0]          hiSum;    // Signed sum of high bytes
  logic [8:0]          loSum;    // Signed sum of low bytes
  logic [9:0]          redSum;   // Sum of both byte sums
  logic [3:0]          shamt;    // Shift amount
  logic [2*DATA_W-1:0] rotWide;  // Doubled word for rotate
  logic [DATA_W-1:0]   nibSum;   // PADDSB result

  // 4-bit signed add, clamped to 0111 or 1000
  function automatic logic [3:0] addNibbleSat(
    input logic [3:0] a,
    input logic [3:0] b
  );
    logic [3:0] s;
    s = a + b;
    if ((a[3] == b[3]) && (s[3] != a[3]))
      return a[3] ? 4'b1000 : 4'b0111;
    return s;
  endfunction

  //////////////////////////////
  // Arithmetic datapaths
  //////////////////////////////
  assign sum  = in1 + in2;
  assign diff = in1 - in2;

  // Overflow only when the result sign disagrees with in1 on a same-sign add
  assign sumOvf  = (in1[DATA_W-1] == in2[DATA_W-1]) && (sum[DATA_W-1] != in1[DATA_W-1]);
  assign diffOvf = (in1[DATA_W-1] != in2[DATA_W-1]) && (diff[DATA_W-1] != in1[DATA_W-1]);
  assign satWord = {in1[DATA_W-1], {(DATA_W-1){~in1[DATA_W-1]}}};  // 0x8000 or 0x7FFF

  assign hiSum  = {in1[DATA_W-1], in1[DATA_W-1 -: 8]} + {in2[DATA_W-1], in2[DATA_W-1 -: 8]};
  assign loSum  = {in1[7], in1[7:0]} + {in2[7], in2[7:0]};
  assign redSum = {hiSum[8], hiSum} + {loSum[8], loSum};

  assign shamt   = in2[3:0];
  assign rotWide = {in1, in1} >> shamt;  // Low half is the rotated word

  always_comb begin
    for (int i = 0; i < DATA_W / 4; i++)
      nibSum[i*4 +: 4] = addNibbleSat(in1[i*4 +: 4], in2[i*4 +: 4]);
  end

  //////////////////////////////
  // Result select
  //////////////////////////////
  always_comb begin
    vSet = 1'b0;  // Only ADD and SUB report overflow
    case (opcode)
      OP_ADD: begin
        result = sumOvf ? satWord : sum;
        vSet   = sumOvf;
      end
      OP_SUB: begin
        result = diffOvf ? satWord : diff;
        vSet   = diffOvf;
      end
      OP_XOR:    result = in1 ^ in2;
      OP_RED:    result = {{(DATA_W-10){redSum[9]}}, redSum};  // Sign extend
      OP_SLL:    result = in1 << shamt;
      OP_SRA:    result = $signed(in1) >>> shamt;
      OP_ROR:    result = rotWide[DATA_W-1:0];
      OP_PADDSB: result = nibSum;
      OP_LLB:    result = {in1[DATA_W-1:8], in2[7:0]};  // Keep high byte
      OP_LHB:    result = {in2[7:0], in1[7:0]};         // Keep low byte
      default:   result = '0;
    endcase
  end

  assign zSet = (result == '0);
  assign nSet = result[DATA_W-1];

endmodule

// File: rtl/ForwardUnit.sv
module ForwardUnit import pipePkg::*; (
  input  logic [REG_W-1:0] rs,        // Source register for operand A
  input  logic [REG_W-1:0] rt,        // Source register for operand B
  fwdIf.sink               fwd,       // In-flight destinations
  output logic [FWD_W-1:0] forwardA,  // Operand A select
  output logic [FWD_W-1:0] forwardB   // Operand B select
);

  // Newest producer wins, r0 is hard zero and never forwarded
  function automatic logic [FWD_W-1:0] pickSource(
    input logic [REG_W-1:0] src,
    input logic             exWrite,
    input logic [REG_W-1:0] exRd,
    input logic             wbWrite,
    input logic [REG_W-1:0] wbRd
  );
    if (src == '0)
      return FWD_NONE;
    if (exWrite && (exRd == src))
      return FWD_EXMEM;  // One instruction back
    if (wbWrite && (wbRd == src))
      return FWD_MEMWB;  // Two instructions back
    return FWD_NONE;
  endfunction

  assign forwardA = pickSource(rs, fwd.exMemWrite, fwd.exMemRd,
                               fwd.memWbWrite, fwd.memWbRd);
  assign forwardB = pickSource(rt, fwd.exMemWrite, fwd.exMemRd,
                               fwd.memWbWrite, fwd.memWbRd);

endmodule

// File: rtl/Execute.sv
module Execute import aluPkg::*, pipePkg::*; (
  input  logic              clk,
  input  logic              rstN,       // Sync, active low
  input  logic              instValid,  // Low for a bubble
  input  logic [DATA_W-1:0] rsData,     // ID/EX read data A
  input  logic [DATA_W-1:0] rtData,     // ID/EX read data B
  input  logic [DATA_W-1:0] imm,        // Immediate from decode
  input  logic [OP_W-1:0]   aluOp,
  input  logic              aluSrc,     // Immediate replaces operand B
  input  logic              zEn,        // Z update enable
  input  logic              nvEn,       // N and V update enable
  input  logic [FWD_W-1:0]  forwardA,
  input  logic [FWD_W-1:0]  forwardB,
  fwdIf.sink                fwd,        // Forwarded results
  output logic [DATA_W-1:0] aluOut,
  output logic [FLAG_W-1:0] flags       // Z, V, N register
);

  logic [DATA_W-1:0] opA;     // ALU input 1
  logic [DATA_W-1:0] opBFwd;  // Operand B after forwarding
  logic [DATA_W-1:0] opB;     // ALU input 2
  logic              zSet;
  logic              nSet;
  logic              vSet;

  function automatic logic [DATA_W-1:0] pickOperand(
    input logic [FWD_W-1:0]  sel,
    input logic [DATA_W-1:0] regVal,
    input logic [DATA_W-1:0] exMemVal,
    input logic [DATA_W-1:0] memWbVal
  );
    case (sel)
      FWD_EXMEM: return exMemVal;
      FWD_MEMWB: return memWbVal;
      default:   return regVal;
    endcase
  endfunction

  //////////////////////////////
  // Operand selection
  //////////////////////////////
  assign opA    = pickOperand(forwardA, rsData, fwd.exMemResult, fwd.memWbResult);
  assign opBFwd = pickOperand(forwardB, rtData, fwd.exMemResult, fwd.memWbResult);
  assign opB    = aluSrc ? imm : opBFwd;  // I-type takes the immediate

  Alu iAlu (
    .in1    (opA),
    .in2    (opB),
    .opcode (aluOp),
    .result (aluOut),
    .zSet   (zSet),
    .nSet   (nSet),
    .vSet   (vSet)
  );

  //////////////////////////////
  // Flag register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else begin
      if (zEn && instValid)
        flags[FLAG_Z] <= zSet;
      if (nvEn && instValid) begin  // N and V share one enable
        flags[FLAG_N] <= nSet;
        flags[FLAG_V] <= vSet;
      end
    end
  end

endmodule

// File: rtl/ResultPipe.sv
module ResultPipe import aluPkg::*, pipePkg::*; (
  input  logic              clk,
  input  logic              rstN,     // Sync, active low
  input  logic [DATA_W-1:0] aluOut,   // Result leaving EX
  input  logic [REG_W-1:0]  rd,       // Destination of the EX instruction
  input  logic              writeEn,  // Valid register write
  fwdIf.source              fwd       // Stage contents for forwarding
);

  // EX/MEM register
  logic [DATA_W-1:0] exMemResult;
  logic [REG_W-1:0]  exMemRd;
  logic              exMemWrite;

  // MEM/WB register
  logic [DATA_W-1:0] memWbResult;
  logic [REG_W-1:0]  memWbRd;
  logic              memWbWrite;

  // Advances every cycle, no stalls
  always_ff @(posedge clk) begin
    if (!rstN) begin
      exMemResult <= '0;
      exMemRd     <= '0;
      exMemWrite  <= 1'b0;
      memWbResult <= '0;
      memWbRd     <= '0;
      memWbWrite  <= 1'b0;
    end else begin
      exMemResult <= aluOut;
      exMemRd     <= rd;
      exMemWrite  <= writeEn;
      memWbResult <= exMemResult;  // No memory access, ALU result passes on
      memWbRd     <= exMemRd;
      memWbWrite  <= exMemWrite;
    end
  end

  assign fwd.exMemResult = exMemResult;
  assign fwd.exMemRd     = exMemRd;
  assign fwd.exMemWrite  = exMemWrite;
  assign fwd.memWbResult = memWbResult;
  assign fwd.memWbRd     = memWbRd;
  assign fwd.memWbWrite  = memWbWrite;

endmodule

// File: rtl/ExecuteTop.sv
module ExecuteTop import aluPkg::*, pipePkg::*; (
  input  logic              clk,
  input  logic              rstN,
  // ID/EX register contents
  input  logic              instValid,
  input  logic              regWrite,
  input  logic              aluSrc,
  input  logic              zEn,
  input  logic              nvEn,
  input  logic [REG_W-1:0]  rs,
  input  logic [REG_W-1:0]  rt,
  input  logic [REG_W-1:0]  rd,
  input  logic [DATA_W-1:0] rsData,
  input  logic [DATA_W-1:0] rtData,
  input  logic [DATA_W-1:0] imm,
  input  logic [OP_W-1:0]   aluOp,
  // Flags and pipeline results
  output logic              zf,
  output logic              nf,
  output logic              vf,
  output logic [DATA_W-1:0] exMemResult,
  output logic [DATA_W-1:0] memWbResult,
  output logic [REG_W-1:0]  wbRd,         // Writeback destination
  output logic              wbWrite       // Writeback enable
);

  logic [FWD_W-1:0]  forwardA;
  logic [FWD_W-1:0]  forwardB;
  logic [DATA_W-1:0] aluOut;
  logic [FLAG_W-1:0] flags;

  fwdIf fwdBus ();  // EX/MEM and MEM/WB feedback

  //////////////////////////////
  // Units
  //////////////////////////////
  ForwardUnit iForwardUnit (
    .rs       (rs),
    .rt       (rt),
    .fwd      (fwdBus.sink),
    .forwardA (forwardA),
    .forwardB (forwardB)
  );

  Execute iExecute (
    .clk       (clk),
    .rstN      (rstN),
    .instValid (instValid),
    .rsData    (rsData),
    .rtData    (rtData),
    .imm       (imm),
    .aluOp     (aluOp),
    .aluSrc    (aluSrc),
    .zEn       (zEn),
    .nvEn      (nvEn),
    .forwardA  (forwardA),
    .forwardB  (forwardB),
    .fwd       (fwdBus.sink),
    .aluOut    (aluOut),
    .flags     (flags)
  );

  ResultPipe iResultPipe (
    .clk     (clk),
    .rstN    (rstN),
    .aluOut  (aluOut),
    .rd      (rd),
    .writeEn (regWrite & instValid),  // Bubbles never write
    .fwd     (fwdBus.source)
  );

  // Outputs
  assign zf          = flags[FLAG_Z];
  assign nf          = flags[FLAG_N];
  assign vf          = flags[FLAG_V];
  assign exMemResult = fwdBus.exMemResult;
  assign memWbResult = fwdBus.memWbResult;
  assign wbRd        = fwdBus.memWbRd;
  assign wbWrite     = fwdBus.memWbWrite;

endmodule

// File: sim/executeTop_chk.sv
module executeTop_chk import aluPkg::*, pipePkg::*; (
  input logic              clk,
  input logic              rstN,
  input logic              instValid,
  input logic              zEn,
  input logic              nvEn,
  input logic [REG_W-1:0]  rs,
  input logic [REG_W-1:0]  rt,
  input logic [FWD_W-1:0]  forwardA,
  input logic [FWD_W-1:0]  forwardB,
  input logic [FLAG_W-1:0] flags,
  input logic              exMemWrite,  // EX/MEM write flag
  input logic              wbWrite      // MEM/WB write flag
);

  // Reset clears both write flags by the next edge
  resetWrites: assert property (@(posedge clk) !rstN |=> (!exMemWrite && !wbWrite))
    else $error("write flag set during or after reset");

  // r0 is a constant, never taken from the pipeline
  noFwdZeroA: assert property (@(posedge clk) (rs == '0) |-> (forwardA == FWD_NONE))
    else $error("operand A forwarded for r0");
  noFwdZeroB: assert property (@(posedge clk) (rt == '0) |-> (forwardB == FWD_NONE))
    else $error("operand B forwarded for r0");

  //////////////////////////////
  // Flag hold
  //////////////////////////////
  zHold: assert property (@(posedge clk) disable iff (!rstN)
    !(zEn && instValid) |=> $stable(flags[FLAG_Z]))
    else $error("Z changed without enable");
  nvHold: assert property (@(posedge clk) disable iff (!rstN)
    !(nvEn && instValid) |=> ($stable(flags[FLAG_N]) && $stable(flags[FLAG_V])))
    else $error("N or V changed without enable");

endmodule

// File: sim/tbExecute.sv
module tbExecute import aluPkg::*, pipePkg::*; ();

  localparam int PERIOD       = 40;  // Clock period
  localparam int RESET_CYCLES = 16;
  localparam int TEST_INSTRS  = 89;  // Instructions issued by all tests together

  // DUT ports
  logic              clk = 1'b0;
  logic              rstN, instValid, regWrite, aluSrc, zEn, nvEn;
  logic [REG_W-1:0]  rs, rt, rd;
  logic [DATA_W-1:0] rsData, rtData, imm;
  logic [OP_W-1:0]   aluOp;
  logic              zf, nf, vf, wbWrite;
  logic [DATA_W-1:0] exMemResult, memWbResult;
  logic [REG_W-1:0]  wbRd;

  int seed = 54;  // $random seed

  // Model of EX/MEM (index 0) and MEM/WB (index 1)
  logic [DATA_W-1:0] qRes[$];
  logic [REG_W-1:0]  qRd[$];
  logic              qWr[$];
  logic [FLAG_W-1:0] expFlags;  // Z, V, N as in the flag vector

  ExecuteTop u_dut (.*);

  bind ExecuteTop executeTop_chk uChk (
    .clk (clk), .rstN (rstN), .instValid (instValid), .zEn (zEn), .nvEn (nvEn),
    .rs (rs), .rt (rt), .forwardA (forwardA), .forwardB (forwardB), .flags (flags),
    .exMemWrite (fwdBus.exMemWrite), .wbWrite (wbWrite)
  );

  always #(PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // Checking and reference model
  //////////////////////////////
  task automatic checkEq(input logic [DATA_W-1:0] actual, input logic [DATA_W-1:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Testbench failed");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  // Expected {overflow, result} worked out with integer arithmetic
  function automatic logic [DATA_W:0] refAlu(
    input logic [OP_W-1:0]   op,
    input logic [DATA_W-1:0] a,
    input logic [DATA_W-1:0] b
  );
    int sa;
    int sb;
    int r;
    int n;
    logic [DATA_W-1:0] res;
    logic              v;
    sa  = int'($signed(a));
    sb  = int'($signed(b));
    n   = int'(b[3:0]);  // Shift count
    v   = 1'b0;
    res = '0;
    case (op)
      OP_ADD, OP_SUB: begin
        r = (op == OP_ADD) ? sa + sb : sa - sb;
        v = (r > 32767) || (r < -32768);  // Outside the signed 16-bit range
        if (r > 32767)
          res = 16'h7FFF;
        else if (r < -32768)
          res = 16'h8000;
        else
          res = r[DATA_W-1:0];
      end
      OP_XOR: res = a ^ b;
      OP_RED: begin
        r   = int'($signed(a[15:8])) + int'($signed(b[15:8]));  // High bytes
        r   = r + int'($signed(a[7:0])) + int'($signed(b[7:0]));  // Plus low bytes
        res = r[DATA_W-1:0];
      end
      OP_SLL: res = a << n;
      OP_SRA: begin
        r   = sa >>> n;
        res = r[DATA_W-1:0];
      end
      OP_ROR: res = (a >> n) | (a << (DATA_W - n));
      OP_PADDSB: begin
        for (int i = 0; i < 4; i++) begin
          r = int'($signed(a[i*4 +: 4])) + int'($signed(b[i*4 +: 4]));
          if (r > 7)
            r = 7;
          else if (r < -8)
            r = -8;
          res[i*4 +: 4] = r[3:0];
        end
      end
      OP_LLB: res = {a[15:8], b[7:0]};
      OP_LHB: res = {b[7:0], a[7:0]};
      default: res = '0;  // Unused codes
    endcase
    return {v, res};
  endfunction

  // Newest writing stage with a matching nonzero destination supplies the operand
  function automatic logic [DATA_W-1:0] fwdValue(input logic [REG_W-1:0] src,
                                                 input logic [DATA_W-1:0] regData);
    for (int i = 0; i < 2; i++)
      if ((src != '0) && qWr[i] && (qRd[i] == src))
        return qRes[i];
    return regData;
  endfunction

  task automatic checkStages();
    checkEq(exMemResult, qRes[0], "EX/MEM result");
    checkEq(memWbResult, qRes[1], "MEM/WB result");
    checkEq(DATA_W'(wbRd), DATA_W'(qRd[1]), "writeback destination");
    checkEq(DATA_W'(wbWrite), DATA_W'(qWr[1]), "writeback enable");
    checkEq(DATA_W'({zf, vf, nf}), DATA_W'(expFlags), "flag register");
  endtask

  // One instruction per falling edge, previous results checked first
  task automatic issue(
    input logic [OP_W-1:0]   op,
    input logic [REG_W-1:0]  s, t, d,
    input logic [DATA_W-1:0] a, b, im,
    input logic              useImm, wr, vld, ze, ne
  );
    logic [DATA_W-1:0] opA;
    logic [DATA_W-1:0] opB;
    logic [DATA_W:0]   expOut;  // {V, result}
    @(negedge clk);
    checkStages();
    opA    = fwdValue(s, a);
    opB    = useImm ? im : fwdValue(t, b);
    expOut = refAlu(op, opA, opB);
    {aluOp, rs, rt, rd}                       = {op, s, t, d};
    {rsData, rtData, imm}                     = {a, b, im};
    {aluSrc, regWrite, instValid, zEn, nvEn}  = {useImm, wr, vld, ze, ne};
    qRes.push_front(expOut[DATA_W-1:0]);
    qRd.push_front(d);
    qWr.push_front(wr && vld);  // Bubbles never write
    void'(qRes.pop_back());
    void'(qRd.pop_back());
    void'(qWr.pop_back());
    if (vld && ze)
      expFlags[FLAG_Z] = (expOut[DATA_W-1:0] == '0);
    if (vld && ne) begin
      expFlags[FLAG_N] = expOut[DATA_W-1];
      expFlags[FLAG_V] = expOut[DATA_W];
    end
  endtask

  task automatic issueReg(input logic [OP_W-1:0] op, input logic [REG_W-1:0] s, t, d,
                          input logic [DATA_W-1:0] a, b);
    issue(op, s, t, d, a, b, 16'h0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1);
  endtask

  task automatic issueBubble();
    issue(OP_ADD, 4'd0, 4'd0, 4'd0, 16'h0, 16'h0, 16'h0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic resetTest();
    checkEq(DATA_W'({zf, vf, nf}), '0, "flags after reset");
    checkEq(exMemResult, '0, "EX/MEM result after reset");
    checkEq(memWbResult, '0, "MEM/WB result after reset");
    checkEq(DATA_W'(wbWrite), '0, "wbWrite after reset");
  endtask

  task automatic aluOpsTest();
    for (int op = 0; op < 16; op++)  // Unused codes too
      for (int k = 0; k < 4; k++)
        issueReg(OP_W'(op), 4'd1, 4'd2, 4'd3, DATA_W'($random(seed)), DATA_W'($random(seed)));
    issueReg(OP_ADD, 4'd1, 4'd2, 4'd3, 16'h7FFF, 16'h0001);     // Clamps high
    issueReg(OP_SUB, 4'd1, 4'd2, 4'd3, 16'h8000, 16'h0001);     // Clamps low
    issueReg(OP_PADDSB, 4'd1, 4'd2, 4'd3, 16'h7787, 16'h1118);  // Per-nibble clamps
  endtask

  task automatic flagsTest();
    issue(OP_XOR, 4'd1, 4'd2, 4'd3, 16'h1234, 16'h1234, 16'h0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1);
    issue(OP_ADD, 4'd1, 4'd2, 4'd3, 16'h0001, 16'h0001, 16'h0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
    issue(OP_ADD, 4'd1, 4'd2, 4'd3, 16'h7FFF, 16'h0001, 16'h0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1);
    issue(OP_SUB, 4'd1, 4'd2, 4'd3, 16'h0000, 16'h0001, 16'h0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0);
    issue(OP_XOR, 4'd1, 4'd2, 4'd3, 16'h5555, 16'h5555, 16'h0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1);
    issue(OP_SUB, 4'd1, 4'd2, 4'd3, 16'h8000, 16'h0001, 16'h0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1);
  endtask

  // Read data on dependent slots is stale on purpose
  task automatic forwardTest();
    issueReg(OP_ADD, 4'd1, 4'd2, 4'd5, 16'h0100, 16'h0023);
    issueReg(OP_ADD, 4'd5, 4'd2, 4'd6, 16'hDEAD, 16'h0001);   // r5 from EX/MEM
    issueReg(OP_XOR, 4'd1, 4'd2, 4'd7, 16'h00F0, 16'h000F);
    issueReg(OP_SUB, 4'd1, 4'd6, 4'd8, 16'h1000, 16'hBEEF);   // r6 from MEM/WB
    issueReg(OP_ADD, 4'd1, 4'd2, 4'd9, 16'h0001, 16'h0001);
    issueReg(OP_ADD, 4'd1, 4'd2, 4'd9, 16'h0010, 16'h0010);
    issueReg(OP_ADD, 4'd9, 4'd9, 4'd10, 16'hFFFF, 16'hFFFF);  // Newer r9 wins
    issueReg(OP_ADD, 4'd1, 4'd2, 4'd0, 16'h0700, 16'h0007);   // Writes r0
    issueReg(OP_ADD, 4'd0, 4'd0, 4'd11, 16'h0003, 16'h0004);  // r0 not forwarded
    issueReg(OP_LLB, 4'd0, 4'd11, 4'd12, 16'hAB00, 16'h1111);
  endtask

  task automatic immBubbleTest();
    issueReg(OP_ADD, 4'd1, 4'd2, 4'd4, 16'h4000, 16'h0004);
    issue(OP_ADD, 4'd4, 4'd4, 4'd5, 16'h0, 16'h0, 16'h0011, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
    issue(OP_XOR, 4'd1, 4'd2, 4'd6, 16'h1111, 16'h2222, 16'h0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    issueReg(OP_ADD, 4'd6, 4'd2, 4'd7, 16'h0005, 16'h0005);  // Bubble r6 is not forwarded
  endtask

  //////////////////////////////
  // Sequence and watchdog
  //////////////////////////////
  initial begin
    rstN = 1'b0;
    // Live saturating SUB held in reset, so every register must be cleared by rstN
    {instValid, regWrite, aluSrc, zEn, nvEn} = 5'b11011;
    {rs, rt, rd, aluOp} = {4'd0, 4'd0, 4'd5, OP_SUB};
    {rsData, rtData, imm} = {16'h8000, 16'h0001, 16'h0000};
    expFlags = '0;
    repeat (2) begin  // Both stages hold zeros after reset
      qRes.push_back('0);
      qRd.push_back('0);
      qWr.push_back(1'b0);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    {instValid, regWrite, aluSrc, zEn, nvEn} = '0;
    {rs, rt, rd, aluOp} = '0;
    {rsData, rtData, imm} = '0;
    rstN = 1'b1;  // The all-zero bubble in this cycle matches the model
    resetTest();
    aluOpsTest();
    flagsTest();
    forwardTest();
    immBubbleTest();
    repeat (2) issueBubble();  // Drain the last results
    $display("Testbench passed");
    $finish;
  end

  initial begin
    #((RESET_CYCLES + TEST_INSTRS + 40) * PERIOD);
    $display("Watchdog timeout: the tests did not finish in time");
    $display("Testbench failed");
    $fatal(1, "Simulation stopped by watchdog");
  end

endmodule

// File: filelist.f
rtl/aluPkg.sv
rtl/pipePkg.sv
rtl/fwdIf.sv
rtl/Alu.sv
rtl/ForwardUnit.sv
rtl/Execute.sv
rtl/ResultPipe.sv
rtl/ExecuteTop.sv
sim/executeTop_chk.sv
sim/tbExecute.sv

// File: run.sh
#!/bin/sh
# Compile and run the execute slice testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module tbExecute -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VtbExecute > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
